// ==== gcd_system.f ====
common/rv_pkg.sv
core/instruction_memory.sv
core/decoder.sv
core/register_file.sv
core/alu.sv
core/cpu_core.sv
logic/data_memory.sv
logic/gcd_system.sv
sim/gcd_system_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build gcd_system_tb with verilator, run it and judge the log
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing -f gcd_system.f --top-module gcd_system_tb > build.log 2>&1 \
    && ./obj_dir/Vgcd_system_tb > "$LOG" 2>&1 \
    || echo "Simulation failed" >> "$LOG"
cat "$LOG"
grep -q "Simulation failed" "$LOG" && echo "run_sim: FAIL" && exit 1
grep -q "Simulation passed" "$LOG" || { echo "run_sim: no result in log"; exit 1; }
echo "run_sim: PASS"
exit 0

// ==== sim/gcd_system_tb.sv ====
`timescale 1ns/1ps

module gcd_system_tb import rv_pkg::*;;

    localparam int DMEM_ADDR_W = 6;
    localparam int CLK_PERIOD  = 20;    // ns
    localparam int RST_CYCLES  = 8;
    localparam int RUN_BOUND   = 1500;  // cycles allowed per gcd run
    localparam int NUM_TESTS   = 20;
    localparam int WATCHDOG_NS = NUM_TESTS * (RST_CYCLES + RUN_BOUND) * CLK_PERIOD;
    localparam word_t SIGN_MASK = 32'h8000_0000;

    logic                   clk;
    logic                   rst;
    logic                   preload_we;
    logic [DMEM_ADDR_W-1:0] preload_addr;
    word_t                  preload_data;
    logic [DMEM_ADDR_W-1:0] dbg_addr;
    word_t                  dbg_data;
    word_t                  pc;
    logic                   halted;

    word_t lfsr_state = 32'd87072; // fixed seed
    int    err_count  = 0;
    int    pass_count = 0;
    int    fail_count = 0;

    gcd_system #(
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) gcd_system_i (
        .clk          (clk),
        .rst          (rst),
        .preload_we   (preload_we),
        .preload_addr (preload_addr),
        .preload_data (preload_data),
        .dbg_addr     (dbg_addr),
        .dbg_data     (dbg_data),
        .pc           (pc),
        .halted       (halted)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic word_t lfsr_next(input word_t s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output word_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state); // one step per bit
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic rand_operand(output word_t v);
        take_bits(8, v);
        while (v == '0) take_bits(8, v); // operands are 1..255
    endtask

    // reference gcd by remainders rather than the program's subtract loop
    function automatic word_t gcd_model(input word_t a, input word_t b);
        word_t x;
        word_t y;
        word_t t;
        x = a;
        y = b;
        while (y != '0) begin
            t = x % y;
            x = y;
            y = t;
        end
        return x;
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string msg);
        if (got !== exp) begin
            err_count++;
            $display("FAIL %0t ns: %s, got 0x%08h expected 0x%08h", $time, msg, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            err_count++;
            $display("FAIL %0t ns: %s, got %b expected %b", $time, msg, got, exp);
        end
    endtask

    // debug port is combinational so sample a quarter period after driving it
    task automatic read_dbg(input logic [DMEM_ADDR_W-1:0] a, output word_t d);
        @(negedge clk);
        dbg_addr = a;
        #(CLK_PERIOD / 4);
        d = dbg_data;
    endtask

    // one preload strobe over a single rising edge
    task automatic preload_word(input logic [DMEM_ADDR_W-1:0] a, input word_t d);
        preload_we   = 1'b1;
        preload_addr = a;
        preload_data = d;
        @(negedge clk);
        preload_we   = 1'b0;
    endtask

    // hold rst for RST_CYCLES rising edges while the operands go in
    task automatic reset_and_preload(input word_t a, input word_t b);
        @(negedge clk);
        rst = 1'b1;
        @(negedge clk); // pc not yet at 0 in the first cycle
        preload_word(6'd1, a);
        preload_word(6'd2, b);
        preload_word(6'd5, SIGN_MASK);
        preload_word(6'd4, '0); // result word cleared to a value no gcd can take
        repeat (RST_CYCLES - 5) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic run_and_check(input word_t a, input word_t b);
        word_t d;
        check_flag(halted, 1'b0, "halted right after reset release");
        check_word(pc, '0, "pc right after reset release");
        while (!halted) @(negedge clk); // watchdog covers a core that never halts
        check_word(pc, HALT_PC, "pc when halted");
        read_dbg(6'd4, d);
        check_word(d, gcd_model(a, b), "gcd in data word 4");
        read_dbg(6'd1, d);
        check_word(d, a, "operand a in word 1");
        read_dbg(6'd2, d);
        check_word(d, b, "operand b in word 2");
        read_dbg(6'd5, d);
        check_word(d, SIGN_MASK, "sign mask in word 5");
        repeat (5) begin
            @(negedge clk);
            check_word(pc, HALT_PC, "pc after halt");
            check_flag(halted, 1'b1, "halted level after halt");
        end
    endtask

    initial begin
        int    errs_before;
        word_t a;
        word_t b;
        word_t first_a;
        string kind;

        clk          = 1'b0;
        rst          = 1'b1;
        preload_we   = 1'b0;
        preload_addr = '0;
        preload_data = '0;
        dbg_addr     = '0;

        for (int t = 0; t < NUM_TESTS; t++) begin
            errs_before = err_count;
            rand_operand(a);
            rand_operand(b);
            kind = "random";
            if (t == 0) begin
                b    = a; // gcd is the operand itself
                kind = "equal";
            end else if (t == 1) begin
                b    = 32'd1;
                kind = "one";
            end else if (t == 2) begin
                // long run with a >= 128 and b = 1 that rst cuts short
                rand_operand(first_a);
                first_a = first_a | 32'h80;
                reset_and_preload(first_a, 32'd1);
                repeat (30) @(negedge clk);
                check_flag(halted, 1'b0, "halted before mid-run reset");
                kind = "mid_reset";
            end
            reset_and_preload(a, b);
            run_and_check(a, b);
            if (err_count == errs_before) begin
                pass_count++;
                $display("test %0d %s a=%0d b=%0d gcd=%0d: passed", t, kind, a, b,
                         gcd_model(a, b));
            end else begin
                fail_count++;
                $display("test %0d %s a=%0d b=%0d gcd=%0d: failed", t, kind, a, b,
                         gcd_model(a, b));
            end
        end

        $display("tests passed %0d, failed %0d, check errors %0d", pass_count, fail_count,
                 err_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // bound on the whole run
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the core never halted within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== logic/gcd_system.sv ====
`timescale 1ns/1ps

module gcd_system import rv_pkg::*; #(
    parameter int DMEM_ADDR_W = 6
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   preload_we,
    input  logic [DMEM_ADDR_W-1:0] preload_addr,
    input  word_t                  preload_data,
    input  logic [DMEM_ADDR_W-1:0] dbg_addr,
    output word_t                  dbg_data,
    output word_t                  pc,
    output logic                   halted
);

    logic [DMEM_ADDR_W-1:0] dmem_addr;
    word_t                  dmem_wdata;
    logic                   dmem_we;
    word_t                  dmem_rdata;

    cpu_core #(
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) cpu_core_i (
        .clk        (clk),
        .rst        (rst),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata),
        .pc         (pc),
        .halted     (halted)
    );

    data_memory #(
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) data_memory_i (
        .clk          (clk),
        .addr         (dmem_addr),
        .wdata        (dmem_wdata),
        .we           (dmem_we),
        .rdata        (dmem_rdata),
        .preload_we   (preload_we),
        .preload_addr (preload_addr),
        .preload_data (preload_data),
        .dbg_addr     (dbg_addr),
        .dbg_data     (dbg_data)
    );

endmodule

// ==== logic/data_memory.sv ====
`timescale 1ns/1ps

module data_memory import rv_pkg::*; #(
    parameter int DMEM_ADDR_W = 6
) (
    input  logic                   clk,
    // core port
    input  logic [DMEM_ADDR_W-1:0] addr,
    input  word_t                  wdata,
    input  logic                   we,
    output word_t                  rdata,
    // preload port, used while the core sits in reset
    input  logic                   preload_we,
    input  logic [DMEM_ADDR_W-1:0] preload_addr,
    input  word_t                  preload_data,
    // debug read
    input  logic [DMEM_ADDR_W-1:0] dbg_addr,
    output word_t                  dbg_data
);

    word_t mem [0:(2**DMEM_ADDR_W)-1];

    // single write port, preload wins over a core store
    always_ff @(posedge clk) begin
        if (preload_we) begin
            mem[preload_addr] <= preload_data;
        end else if (we) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata    = mem[addr];     // load path
    assign dbg_data = mem[dbg_addr]; // no cycle cost

endmodule

// ==== core/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core import rv_pkg::*; #(
    parameter int DMEM_ADDR_W = 6
) (
    input  logic                   clk,
    input  logic                   rst,
    output logic [DMEM_ADDR_W-1:0] dmem_addr,  // word index into data memory
    output word_t                  dmem_wdata,
    output logic                   dmem_we,
    input  word_t                  dmem_rdata,
    output word_t                  pc,         // byte address of current instr
    output logic                   halted
);

    word_t     instr;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    alu_op_t   alu_op;
    logic      alu_src_imm;
    logic      reg_we;
    logic      mem_read;
    logic      mem_write;
    logic      branch;
    word_t     imm;
    word_t     rdata_a;
    word_t     rdata_b;
    word_t     alu_b;
    word_t     alu_result;
    logic      alu_zero;
    word_t     wb_data;
    logic      br_taken;
    word_t     pc_next;

    // fetch by word index
    instruction_memory instruction_memory_i (
        .i_mem_addr (pc[7:2]),
        .i_mem_data (instr)
    );

    decoder decoder_i (
        .instr       (instr),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .alu_op      (alu_op),
        .alu_src_imm (alu_src_imm),
        .reg_we      (reg_we),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .branch      (branch),
        .imm         (imm)
    );

    register_file register_file_i (
        .clk     (clk),
        .we      (reg_we),
        .ra      (rs1),
        .rb      (rs2),
        .rw      (rd),
        .wdata   (wb_data),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    assign alu_b = alu_src_imm ? imm : rdata_b;

    alu alu_i (
        .a      (rdata_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // data memory is word indexed straight from the effective address
    assign dmem_addr  = alu_result[DMEM_ADDR_W-1:0];
    assign dmem_wdata = rdata_b;
    assign dmem_we    = mem_write & ~rst; // no stores while in reset

    assign wb_data = mem_read ? dmem_rdata : alu_result;

    // next pc
    assign br_taken = branch & alu_zero;
    assign pc_next  = br_taken ? (pc + imm) : (pc + 32'd4);

    // a taken branch onto itself ends the program
    assign halted = br_taken && (imm == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

// ==== core/alu.sv ====
`timescale 1ns/1ps

module alu import rv_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   result,
    output logic    zero    // beq takes this as a == b
);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== core/register_file.sv ====
`timescale 1ns/1ps

module register_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      we,
    input  reg_addr_t ra,      // read port a
    input  reg_addr_t rb,      // read port b
    input  reg_addr_t rw,      // write port
    input  word_t     wdata,
    output word_t     rdata_a,
    output word_t     rdata_b
);

    word_t regs [0:31];

    // x0 hardwired to zero on reads
    assign rdata_a = (ra == '0) ? '0 : regs[ra];
    assign rdata_b = (rb == '0) ? '0 : regs[rb];

    always_ff @(posedge clk) begin
        if (we && rw != '0) begin // drop writes to x0
            regs[rw] <= wdata;
        end
    end

endmodule

// ==== core/decoder.sv ====
`timescale 1ns/1ps

module decoder import rv_pkg::*; (
    input  word_t     instr,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd,
    output alu_op_t   alu_op,
    output logic      alu_src_imm, // b operand from imm instead of rs2
    output logic      reg_we,
    output logic      mem_read,    // write-back from data memory
    output logic      mem_write,
    output logic      branch,
    output word_t     imm
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    // sign extended immediates, bit 31 is always the sign
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        // defaults give a nop
        alu_op      = ALU_ADD;
        alu_src_imm = 1'b0;
        reg_we      = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        branch      = 1'b0;
        imm         = imm_i;

        case (opcode)
            OP_LOAD: begin // funct3 ignored, always a word
                alu_src_imm = 1'b1;
                reg_we      = 1'b1;
                mem_read    = 1'b1;
            end
            OP_OPIMM: begin // only addi is decoded
                alu_src_imm = 1'b1;
                reg_we      = (funct3 == FUNCT3_ADD_SUB);
            end
            OP_STORE: begin
                alu_src_imm = 1'b1;
                mem_write   = 1'b1;
                imm         = imm_s;
            end
            OP_REG: begin
                reg_we = 1'b1;
                case (funct3)
                    FUNCT3_ADD_SUB: alu_op = (funct7 == FUNCT7_SUB) ? ALU_SUB : ALU_ADD;
                    FUNCT3_AND:     alu_op = ALU_AND;
                    FUNCT3_OR:      alu_op = ALU_OR;
                    default:        reg_we = 1'b0; // not in the subset
                endcase
            end
            OP_BRANCH: begin // beq only, equality via subtract
                alu_op = ALU_SUB;
                branch = (funct3 == FUNCT3_BEQ);
                imm    = imm_b;
            end
            default: ; // unknown opcode, no side effects
        endcase
    end

endmodule

// ==== core/instruction_memory.sv ====
`timescale 1ns/1ps

module instruction_memory import rv_pkg::*; (
    input  imem_addr_t i_mem_addr, // word index, pc[7:2]
    output word_t      i_mem_data  // instruction at that word
);

    word_t mem [0:63];

    assign i_mem_data = mem[i_mem_addr]; // async read

    // field layouts
    // I  imm[11:0] | rs1 | f3 | rd | op
    // R  f7 | rs2 | rs1 | f3 | rd | op
    // S  imm[11:5] | rs2 | rs1 | f3 | imm[4:0] | op
    // B  imm[12] | imm[10:5] | rs2 | rs1 | f3 | imm[4:1] | imm[11] | op
    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = '0; // unused words read as zero
        end

        // euclid by repeated subtraction, a in word 1, b in word 2, mask in word 5
        mem[0]  = {12'd1, X0, FUNCT3_LOAD, X1, OP_LOAD};               // 0   ld x1,1(x0)
        mem[1]  = {12'd2, X0, FUNCT3_LOAD, X2, OP_LOAD};               // 4   ld x2,2(x0)
        mem[2]  = {12'd5, X0, FUNCT3_LOAD, X5, OP_LOAD};               // 8   ld x5,5(x0)
        mem[3]  = {12'd0, X0, FUNCT3_LOAD, X0, OP_LOAD};               // 12  ld x0 (no effect)

        // loop head
        mem[4]  = {FUNCT7_SUB, X2, X1, FUNCT3_ADD_SUB, X3, OP_REG};    // 16  sub x3,x1,x2
        mem[5]  = {1'b0, 6'b000001, X3, X0, FUNCT3_BEQ, 4'b0000, 1'b0,
                   OP_BRANCH};                                         // 20  beq x0,x3,+32 -> 52
        mem[6]  = {FUNCT7_BASE, X3, X5, FUNCT3_AND, X6, OP_REG};       // 24  and x6,x5,x3
        mem[7]  = {1'b0, 6'b000000, X6, X5, FUNCT3_BEQ, 4'b1000, 1'b0,
                   OP_BRANCH};                                         // 28  beq x5,x6,+16 -> 44

        // a > b
        mem[8]  = {FUNCT7_SUB, X2, X1, FUNCT3_ADD_SUB, X1, OP_REG};    // 32  sub x1,x1,x2
        mem[9]  = {1'b1, 6'b111111, X0, X0, FUNCT3_BEQ, 4'b0110, 1'b1,
                   OP_BRANCH};                                         // 36  beq x0,x0,-20 -> 16
        mem[10] = {1'b0, 6'b000000, X0, X0, FUNCT3_BEQ, 4'b0110, 1'b0,
                   OP_BRANCH};                                         // 40  beq x0,x0,+12, never hit

        // a < b
        mem[11] = {FUNCT7_SUB, X1, X2, FUNCT3_ADD_SUB, X2, OP_REG};    // 44  sub x2,x2,x1
        mem[12] = {1'b1, 6'b111111, X0, X0, FUNCT3_BEQ, 4'b0000, 1'b1,
                   OP_BRANCH};                                         // 48  beq x0,x0,-32 -> 16

        // done, store and park
        mem[13] = {FUNCT7_BASE, X1, X0, FUNCT3_SW, 5'd4, OP_STORE};    // 52  sw x1,4(x0)
        mem[14] = {1'b0, 6'b000000, X0, X0, FUNCT3_BEQ, 4'b0000, 1'b0,
                   OP_BRANCH};                                         // 56  beq x0,x0,0 halt
    end

endmodule

// ==== common/rv_pkg.sv ====
package rv_pkg;

    // basic widths
    typedef logic [31:0] word_t;      // data, instruction or pc value
    typedef logic [4:0]  reg_addr_t;  // x0..x31
    typedef logic [5:0]  imem_addr_t; // instruction word index, pc[7:2]

    // alu operations the core needs
    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR
    } alu_op_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_OPIMM  = 7'b0010011,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_BRANCH = 7'b1100011
    } opcode_t;

    // funct3 values
    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;
    localparam logic [2:0] FUNCT3_BEQ     = 3'b000;
    localparam logic [2:0] FUNCT3_LOAD    = 3'b001; // program encoding, loaded as a full word
    localparam logic [2:0] FUNCT3_SW      = 3'b010;

    // funct7 values
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_SUB  = 7'b0100000;

    // register numbers used by the euclid program
    localparam reg_addr_t X0 = 5'd0;
    localparam reg_addr_t X1 = 5'd1; // operand a, holds the result at the end
    localparam reg_addr_t X2 = 5'd2; // operand b
    localparam reg_addr_t X3 = 5'd3; // difference
    localparam reg_addr_t X5 = 5'd5; // sign mask
    localparam reg_addr_t X6 = 5'd6; // masked difference

    // byte address of the final self branch of the program
    localparam word_t HALT_PC = 32'd56;

endpackage
